//--- hw/i2cPkg.sv
//////////////////////////////////////////////////////////////////////
// I2C master shared definitions
// Register map, command word layout and bit engine states
//////////////////////////////////////////////////////////////////////

package i2cPkg;

	//////////////////////////////////////////////////////////////////////
	// APB register map
	//////////////////////////////////////////////////////////////////////

	// Transmit command word, write only
	localparam logic [31:0] regTxAddr = 32'd0;
	// Received byte, read
	localparam logic [31:0] regRxAddr = 32'd4;
	// Divider configuration, a write also clears the error
	localparam logic [31:0] regCfgAddr = 32'd8;
	// SCL stretch timeout in PCLK cycles, zero turns it off
	localparam logic [31:0] regTimeoutAddr = 32'd12;

	// Width of the configuration and timeout registers
	localparam int regWidth = 14;

	//////////////////////////////////////////////////////////////////////
	// Command word layout
	//////////////////////////////////////////////////////////////////////

	localparam int cmdWidth = 11;
	// Byte to send, bits 7 to 0
	localparam int cmdByteLsb = 0;
	// START before the byte
	localparam int cmdStartBit = 8;
	// STOP after the byte
	localparam int cmdStopBit = 9;
	// Byte is read from the slave
	localparam int cmdReadBit = 10;

	// Bit engine states, each one lasts an SCL half period
	typedef enum logic [3:0] {
		idle, startA, startB, bitLow, bitHigh, ackLow, ackHigh, stopA, stopB
	} engineState;

endpackage

//--- hw/syncFifo.sv
//////////////////////////////////////////////////////////////////////
// Synchronous FIFO
// Circular buffer with extended pointers for full and empty flags
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module syncFifo
#(
	parameter int fifoDepth = 4,
	parameter int width = 8
)
(
	input logic PCLK,
	input logic PRESETn,
	input logic push,
	input logic pop,
	input logic [width-1:0] wrData,
	output logic [width-1:0] rdData,
	output logic empty,
	output logic full
);

	// Address bits, pointers carry one extra wrap bit
	localparam int addrW = $clog2(fifoDepth);

	logic [width-1:0] mem [fifoDepth];
	logic [addrW:0] wrPtr;
	logic [addrW:0] rdPtr;

	// Same wrap bit and address means nothing stored
	assign empty = (wrPtr == rdPtr);
	// Opposite wrap bit with equal address means all slots used
	assign full = (wrPtr[addrW] != rdPtr[addrW]) &&
		(wrPtr[addrW-1:0] == rdPtr[addrW-1:0]);

	// Head of the queue, valid while not empty
	assign rdData = mem[rdPtr[addrW-1:0]];

	// Storage
	always_ff @(posedge PCLK)
	begin
		if (push)
			mem[wrPtr[addrW-1:0]] <= wrData;
	end

	// Pointers, push and pop may coincide
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
		end
	end

	assert property (@(posedge PCLK) disable iff (!PRESETn) pop |-> !empty);
	assert property (@(posedge PCLK) disable iff (!PRESETn) push |-> !full);

endmodule

//--- hw/apbRegs.sv
//////////////////////////////////////////////////////////////////////
// APB register block
// Decodes the register map, strobes the FIFOs, holds the divider and
// timeout registers and stalls pReady on a full or empty FIFO
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module apbRegs
(
	input logic PCLK,
	input logic PRESETn,
	// APB slave side
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input logic [31:0] pAddr,
	input logic [31:0] pWdata,
	output logic [31:0] pRdata,
	output logic pReady,
	output logic pSlvErr,
	// Core status
	input logic txFull,
	input logic rxEmpty,
	input logic errFlag,
	input logic [7:0] rxHead,
	// FIFO strobes and config
	output logic txPush,
	output logic rxPop,
	output logic cfgWrite,
	output logic [i2cPkg::cmdWidth-1:0] txData,
	output logic [i2cPkg::regWidth-1:0] cfgDiv,
	output logic [i2cPkg::regWidth-1:0] cfgTimeout
);

	logic access;
	logic txSel;
	logic rxSel;
	logic toSel;

	// APB access phase
	assign access = pSel & pEnable;

	// Address decode, only the matching direction counts
	assign txSel = access & pWrite & (pAddr == i2cPkg::regTxAddr);
	assign rxSel = access & ~pWrite & (pAddr == i2cPkg::regRxAddr);
	assign cfgWrite = access & pWrite & (pAddr == i2cPkg::regCfgAddr);
	assign toSel = access & pWrite & (pAddr == i2cPkg::regTimeoutAddr);

	// Stall a TX write on a full FIFO, an RX read on an empty one
	assign pReady = access & ~(txSel & txFull) & ~(rxSel & rxEmpty);

	// Strobes fire only in the completing cycle
	assign txPush = txSel & ~txFull;
	assign rxPop = rxSel & ~rxEmpty;
	assign txData = pWdata[i2cPkg::cmdWidth-1:0];

	// Error comes straight from the engine
	assign pSlvErr = errFlag;

	//////////////////////////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		pRdata = '0;
		if (rxSel)
			pRdata = {24'd0, rxHead};
		// Config registers read back for debug
		else if (pAddr == i2cPkg::regCfgAddr)
			pRdata = {{(32-i2cPkg::regWidth){1'b0}}, cfgDiv};
		else if (pAddr == i2cPkg::regTimeoutAddr)
			pRdata = {{(32-i2cPkg::regWidth){1'b0}}, cfgTimeout};
	end

	//////////////////////////////////////////////////////////////////////
	// Divider and timeout registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			cfgDiv <= '0;
			cfgTimeout <= '0;
		end
		else
		begin
			if (cfgWrite)
				cfgDiv <= pWdata[i2cPkg::regWidth-1:0];
			if (toSel)
				cfgTimeout <= pWdata[i2cPkg::regWidth-1:0];
		end
	end

	// Access phase only comes with the slave selected
	assert property (@(posedge PCLK) disable iff (!PRESETn) pEnable |-> pSel);

	// A stalled access keeps its address, direction and data
	assert property (@(posedge PCLK) disable iff (!PRESETn)
		(access && !pReady) |=> (access && $stable(pAddr) && $stable(pWrite) &&
		$stable(pWdata)));

endmodule

//--- hw/i2cBitEngine.sv
//////////////////////////////////////////////////////////////////////
// I2C master bit engine
// Runs one command word per pass: START, eight bits, acknowledge and
// STOP, with SCL stretch timeout and a sticky error flag
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module i2cBitEngine
(
	input logic PCLK,
	input logic PRESETn,
	input logic txEmpty,
	input logic [i2cPkg::cmdWidth-1:0] txHead,
	input logic rxFull,
	input logic [i2cPkg::regWidth-1:0] cfgDiv,
	input logic [i2cPkg::regWidth-1:0] cfgTimeout,
	input logic cfgWrite,
	input logic sclIn,
	input logic sdaIn,
	output logic txPop,
	output logic rxPush,
	output logic [7:0] rxByte,
	output logic sclOe,
	output logic sdaOe,
	output logic errFlag
);

	i2cPkg::engineState state;
	i2cPkg::engineState nextState;

	logic [i2cPkg::regWidth-1:0] divCnt;
	logic [i2cPkg::regWidth-1:0] stretchCnt;
	logic [2:0] bitCnt;
	logic [7:0] shReg;
	logic busHeld;
	logic sdaNext;
	logic [7:0] txByte;
	logic cmdRead;
	logic cmdStop;
	logic cmdGo;
	logic stretched;
	logic halfDone;
	logic nackHit;
	logic timeoutHit;

	// Command fields, the word stays at the FIFO head until txPop
	assign txByte = txHead[i2cPkg::cmdByteLsb +: 8];
	assign cmdRead = txHead[i2cPkg::cmdReadBit];
	assign cmdStop = txHead[i2cPkg::cmdStopBit];

	// Start only with no error pending and room for a read byte
	assign cmdGo = !txEmpty && !errFlag && !(cmdRead && rxFull);

	// SCL pulled low by the engine in low phases and while holding the bus
	always_comb
	begin
		case (state)
			i2cPkg::idle: sclOe = busHeld;
			i2cPkg::bitLow, i2cPkg::ackLow, i2cPkg::stopA: sclOe = 1'b1;
			default: sclOe = 1'b0;
		endcase
	end

	// Slave holds SCL low after we released it
	assign stretched = (state != i2cPkg::idle) && !sclOe && !sclIn;
	// Half period is cfgDiv+1 cycles, frozen during a stretch
	assign halfDone = (state != i2cPkg::idle) && !stretched && (divCnt >= cfgDiv);
	assign timeoutHit = stretched && (cfgTimeout != '0) && (stretchCnt >= cfgTimeout);
	// Slave left SDA high on the ninth bit of a write
	assign nackHit = (state == i2cPkg::ackHigh) && halfDone && !cmdRead && sdaIn;

	// SDA value for the current state, applied one cycle late
	always_comb
	begin
		case (state)
			i2cPkg::startB, i2cPkg::stopA, i2cPkg::stopB: sdaNext = 1'b1;
			i2cPkg::bitLow, i2cPkg::bitHigh: sdaNext = !cmdRead && !txByte[bitCnt];
			// ACK a read byte unless it is the last one
			i2cPkg::ackLow, i2cPkg::ackHigh: sdaNext = cmdRead && !cmdStop;
			default: sdaNext = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		case (state)
			i2cPkg::idle:
				if (cmdGo)
					nextState = txHead[i2cPkg::cmdStartBit] ? i2cPkg::startA : i2cPkg::bitLow;
			i2cPkg::startA: if (halfDone) nextState = i2cPkg::startB;
			i2cPkg::startB: if (halfDone) nextState = i2cPkg::bitLow;
			i2cPkg::bitLow: if (halfDone) nextState = i2cPkg::bitHigh;
			i2cPkg::bitHigh:
				if (halfDone)
					nextState = (bitCnt == 3'd0) ? i2cPkg::ackLow : i2cPkg::bitLow;
			i2cPkg::ackLow: if (halfDone) nextState = i2cPkg::ackHigh;
			i2cPkg::ackHigh:
				if (halfDone)
					nextState = (nackHit || !cmdStop) ? i2cPkg::idle : i2cPkg::stopA;
			i2cPkg::stopA: if (halfDone) nextState = i2cPkg::stopB;
			i2cPkg::stopB: if (halfDone) nextState = i2cPkg::idle;
			default: nextState = i2cPkg::idle;
		endcase
		// Timeout drops the command wherever it is
		if (timeoutHit)
			nextState = i2cPkg::idle;
	end

	// Command retires after its ninth bit or its STOP, or on an error
	assign txPop = timeoutHit || (halfDone && (((state == i2cPkg::ackHigh) &&
		(nackHit || !cmdStop)) || (state == i2cPkg::stopB)));
	assign rxPush = (state == i2cPkg::ackHigh) && halfDone && cmdRead;
	assign rxByte = shReg;

	//////////////////////////////////////////////////////////////////////
	// Counters and flags
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state <= i2cPkg::idle;
			divCnt <= '0;
			stretchCnt <= '0;
			bitCnt <= '0;
			busHeld <= 1'b0;
			errFlag <= 1'b0;
			sdaOe <= 1'b0;
		end
		else
		begin
			state <= nextState;
			// Lag keeps SDA edges inside the SCL low phase, needs cfgDiv >= 1
			sdaOe <= sdaNext;
			// Divider restarts on every state change
			if (nextState != state || state == i2cPkg::idle)
				divCnt <= '0;
			else if (!stretched)
				divCnt <= divCnt + 1'b1;
			if (stretched)
				stretchCnt <= stretchCnt + 1'b1;
			else
				stretchCnt <= '0;
			// MSB first
			if (state == i2cPkg::idle && cmdGo)
				bitCnt <= 3'd7;
			else if (state == i2cPkg::bitHigh && halfDone)
				bitCnt <= bitCnt - 1'b1;
			// Keep SCL low between commands until a STOP
			if (nackHit || timeoutHit || (state == i2cPkg::stopB && halfDone))
				busHeld <= 1'b0;
			else if (state == i2cPkg::ackHigh && halfDone && !cmdStop)
				busHeld <= 1'b1;
			// Sticky until the next config write, a new error wins
			if (nackHit || timeoutHit)
				errFlag <= 1'b1;
			else if (cfgWrite)
				errFlag <= 1'b0;
		end
	end

	// Read data, sampled at the end of each SCL high phase
	always_ff @(posedge PCLK)
	begin
		if (state == i2cPkg::bitHigh && halfDone && cmdRead)
			shReg <= {shReg[6:0], sdaIn};
	end

	// SDA only moves under a high SCL for START and STOP
	assert property (@(posedge PCLK) disable iff (!PRESETn)
		(!sclOe && $past(!sclOe) && sclIn && $past(sclIn) &&
		state != i2cPkg::startB && $past(state, 2) != i2cPkg::stopB) |-> $stable(sdaOe));

endmodule

//--- hw/apbI2c.sv
//////////////////////////////////////////////////////////////////////
// APB to I2C master top level
// Register block, command and receive FIFOs and the bit engine
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module apbI2c
#(
	parameter int fifoDepth = 4
)
(
	input logic PCLK,
	input logic PRESETn,
	// APB
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input logic [31:0] pAddr,
	input logic [31:0] pWdata,
	output logic [31:0] pRdata,
	output logic pReady,
	output logic pSlvErr,
	// Empty FIFO levels
	output logic intTx,
	output logic intRx,
	// Open-drain I2C pins
	input logic sclIn,
	input logic sdaIn,
	output logic sclOe,
	output logic sdaOe
);

	logic txPush;
	logic txPop;
	logic txEmpty;
	logic txFull;
	logic [i2cPkg::cmdWidth-1:0] txData;
	logic [i2cPkg::cmdWidth-1:0] txHead;
	logic rxPush;
	logic rxPop;
	logic rxEmpty;
	logic rxFull;
	logic [7:0] rxByte;
	logic [7:0] rxHead;
	logic cfgWrite;
	logic errFlag;
	logic [i2cPkg::regWidth-1:0] cfgDiv;
	logic [i2cPkg::regWidth-1:0] cfgTimeout;

	// Interrupt levels
	assign intTx = txEmpty;
	assign intRx = rxEmpty;

	apbRegs regs_i (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
		.pAddr(pAddr), .pWdata(pWdata),
		.pRdata(pRdata), .pReady(pReady), .pSlvErr(pSlvErr),
		.txFull(txFull), .rxEmpty(rxEmpty), .errFlag(errFlag), .rxHead(rxHead),
		.txPush(txPush), .rxPop(rxPop), .cfgWrite(cfgWrite), .txData(txData),
		.cfgDiv(cfgDiv), .cfgTimeout(cfgTimeout)
	);

	// Command words from software
	syncFifo #(.fifoDepth(fifoDepth), .width(i2cPkg::cmdWidth)) txFifo (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.push(txPush), .pop(txPop), .wrData(txData),
		.rdData(txHead), .empty(txEmpty), .full(txFull)
	);

	// Bytes read from the slave
	syncFifo #(.fifoDepth(fifoDepth), .width(8)) rxFifo (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.push(rxPush), .pop(rxPop), .wrData(rxByte),
		.rdData(rxHead), .empty(rxEmpty), .full(rxFull)
	);

	i2cBitEngine engine_i (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.txEmpty(txEmpty), .txHead(txHead), .rxFull(rxFull),
		.cfgDiv(cfgDiv), .cfgTimeout(cfgTimeout), .cfgWrite(cfgWrite),
		.sclIn(sclIn), .sdaIn(sdaIn),
		.txPop(txPop), .rxPush(rxPush), .rxByte(rxByte),
		.sclOe(sclOe), .sdaOe(sdaOe), .errFlag(errFlag)
	);

endmodule

//--- test/i2cSlaveModel.sv
//////////////////////////////////////////////////////////////////////
// Behavioral I2C slave
// Fixed address, one-byte memory, optional SCL stretch after each byte
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module i2cSlaveModel
#(
	parameter logic [6:0] devAddr = 7'h50
)
(
	input logic PCLK,
	input logic scl,
	input logic sda,
	input int stretchLen,
	output logic sclOe,
	output logic sdaOe
);

	int stopCnt = 0;
	int bitIdx = 0;
	int holdCnt = 0;
	logic [31:0] wrLog = '0;
	logic [7:0] mem = '0;
	logic [7:0] shift = '0;
	logic sclPrev = 1'b1;
	logic sdaPrev = 1'b1;
	logic ackPhase = 1'b0;
	logic addrPhase = 1'b0;
	logic active = 1'b0;
	logic isRead = 1'b0;
	logic masterNack = 1'b0;

	initial sdaOe = 1'b0;

	assign sclOe = (holdCnt != 0);

	always @(posedge PCLK)
	begin
		sclPrev <= scl;
		sdaPrev <= sda;
		if (holdCnt != 0)
			holdCnt <= holdCnt - 1;
		// START resets the byte framing
		if (sclPrev && scl && sdaPrev && !sda)
		begin
			bitIdx <= 0;
			ackPhase <= 1'b0;
			addrPhase <= 1'b1;
			active <= 1'b0;
			masterNack <= 1'b0;
			sdaOe <= 1'b0;
		end
		else if (sclPrev && scl && !sdaPrev && sda)
		begin
			stopCnt <= stopCnt + 1;
			active <= 1'b0;
			addrPhase <= 1'b0;
			sdaOe <= 1'b0;
		end
		// Rising SCL samples data or the master acknowledge
		else if (!sclPrev && scl)
		begin
			if (ackPhase)
				masterNack <= sda;
			else if (bitIdx < 8)
			begin
				shift <= {shift[6:0], sda};
				bitIdx <= bitIdx + 1;
			end
		end
		// Falling SCL moves our SDA output
		else if (sclPrev && !scl)
		begin
			if (ackPhase)
			begin
				ackPhase <= 1'b0;
				bitIdx <= 0;
				if (active && stretchLen > 0)
					holdCnt <= stretchLen;
				if (active && isRead && !masterNack)
					sdaOe <= !mem[7];
				else
				begin
					sdaOe <= 1'b0;
					if (masterNack)
						active <= 1'b0;
				end
			end
			else if (bitIdx == 8)
			begin
				ackPhase <= 1'b1;
				if (addrPhase)
				begin
					addrPhase <= 1'b0;
					active <= (shift[7:1] == devAddr);
					isRead <= shift[0];
					sdaOe <= (shift[7:1] == devAddr);
				end
				else if (active && !isRead)
				begin
					mem <= shift;
					wrLog <= {wrLog[23:0], shift};
					sdaOe <= 1'b1;
				end
				else
					sdaOe <= 1'b0;
			end
			else if (active && isRead)
				sdaOe <= !mem[7 - bitIdx];
		end
	end

endmodule

//--- test/apbI2cTb.sv
//////////////////////////////////////////////////////////////////////
// APB I2C master testbench
// Replays the command trace over APB against a behavioral I2C slave
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module apbI2cTb;

	localparam int waitLimit = 20000;

	logic PCLK;
	logic PRESETn;
	logic pSel;
	logic pEnable;
	logic pWrite;
	logic [31:0] pAddr;
	logic [31:0] pWdata;
	logic [31:0] pRdata;
	logic pReady;
	logic pSlvErr;
	logic intTx;
	logic intRx;
	logic sclOe;
	logic sdaOe;
	logic slvSclOe;
	logic slvSdaOe;
	logic sclLine;
	logic sdaLine;
	int stretchCycles;
	int stopsSeen;

	// Open-drain bus with pull-ups
	assign sclLine = ~(sclOe | slvSclOe);
	assign sdaLine = ~(sdaOe | slvSdaOe);

	apbI2c #(.fifoDepth(4)) dut_i (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
		.pAddr(pAddr), .pWdata(pWdata),
		.pRdata(pRdata), .pReady(pReady), .pSlvErr(pSlvErr),
		.intTx(intTx), .intRx(intRx),
		.sclIn(sclLine), .sdaIn(sdaLine), .sclOe(sclOe), .sdaOe(sdaOe)
	);

	i2cSlaveModel slave_i (
		.PCLK(PCLK), .scl(sclLine), .sda(sdaLine), .stretchLen(stretchCycles),
		.sclOe(slvSclOe), .sdaOe(slvSdaOe)
	);

	initial
	begin
		PCLK = 1'b0;
		forever #4 PCLK = ~PCLK;
	end

	// Ends the run after a failed check or a stuck wait
	task automatic abortRun();
		$display("Test failures found");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
			abortRun();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// APB master, setup phase then access phase until pReady
	//////////////////////////////////////////////////////////////////////

	task automatic apbAccess(logic wr, logic [31:0] addr, logic [31:0] data,
		output logic [31:0] rdata);
		int cycles;
		logic done;
		cycles = 0;
		done = 1'b0;
		@(posedge PCLK);
		pSel <= 1'b1;
		pEnable <= 1'b0;
		pWrite <= wr;
		pAddr <= addr;
		pWdata <= data;
		@(posedge PCLK);
		pEnable <= 1'b1;
		while (!done)
		begin
			@(posedge PCLK);
			cycles++;
			done = pReady;
			rdata = pRdata;
			if (!done && cycles > waitLimit)
			begin
				$display("APB access to 0x%0h never completed", addr);
				abortRun();
			end
		end
		pSel <= 1'b0;
		pEnable <= 1'b0;
	endtask

	// Waits for err, intTx and intRx to reach the expected levels
	task automatic expectFlags(string name, logic [2:0] expected);
		int cycles;
		cycles = 0;
		@(posedge PCLK);
		while ({pSlvErr, intTx, intRx} !== expected && cycles < waitLimit)
		begin
			@(posedge PCLK);
			cycles++;
		end
		if (cycles >= waitLimit)
			$display("Flags wait ran out, engine in state %s", dut_i.engine_i.state.name());
		checkValue(name, expected, {29'd0, pSlvErr, intTx, intRx});
	endtask

	// Waits for the next STOP on the bus and checks the slave write log
	task automatic expectStop(string name, logic [31:0] expectedLog);
		int cycles;
		cycles = 0;
		while (slave_i.stopCnt <= stopsSeen)
		begin
			@(posedge PCLK);
			cycles++;
			if (cycles > waitLimit)
			begin
				$display("No STOP seen, engine in state %s", dut_i.engine_i.state.name());
				abortRun();
			end
		end
		stopsSeen = slave_i.stopCnt;
		checkValue(name, expectedLog, slave_i.wrLog);
	endtask

	initial
	begin
		int fd;
		int lineNo;
		int rc;
		string line;
		string name;
		logic [31:0] opA;
		logic [31:0] opB;
		logic [31:0] opC;
		logic [31:0] rdata;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = '0;
		pWdata = '0;
		PRESETn = 1'b0;
		stretchCycles = 0;
		stopsSeen = 0;
		lineNo = 0;
		repeat (8) @(posedge PCLK);
		PRESETn <= 1'b1;
		// Bus stays released with nothing queued
		repeat (16)
		begin
			@(posedge PCLK);
			checkValue("idle bus after reset", 32'd0, {30'd0, sclOe, sdaOe});
		end
		fd = $fopen("test/apbI2cTrace.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the trace file test/apbI2cTrace.txt");
			abortRun();
		end
		while (!$feof(fd))
		begin
			rc = $fgets(line, fd);
			lineNo++;
			if (rc == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			opA = '0;
			opB = '0;
			opC = '0;
			rc = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", opA, opB, opC);
			name = $sformatf("trace line %0d (%s)", lineNo, line.substr(0, 0));
			case (line.getc(0))
				"W": apbAccess(1'b1, opA, opB, rdata);
				"R":
				begin
					apbAccess(1'b0, opA, 32'd0, rdata);
					checkValue(name, opB, rdata);
				end
				"E": expectFlags(name, {opA[0], opB[0], opC[0]});
				"P": expectStop(name, opA);
				"H": stretchCycles = int'(opA);
				default:
				begin
					$display("Unknown trace command on line %0d", lineNo);
					abortRun();
				end
			endcase
		end
		$fclose(fd);
		$display("All tests passed!");
		$finish;
	end

endmodule

//--- test/apbI2cTrace.txt
# W addr data | R addr expected | E pSlvErr intTx intRx | P slave write log | H stretch
# All operands hex; W 0 takes {read, stop, start, byte}
E 0 1 1
W 8 4
W c 14
R 8 4
W 0 1a0
W 0 25c
P 5c
E 0 1 1
W 0 1a1
W 0 600
E 0 1 0
P 5c
R 4 5c
E 0 1 1
W 0 3a2
E 1 1 1
W 8 4
E 0 1 1
H a
W 0 1a0
W 0 277
P 5c77
E 0 1 1
H 64
W 0 1a0
W 0 233
E 1 1 1
W c 0
W 8 4
H 0
E 0 1 1
W 8 14
W 0 1a0
W 0 11
W 0 22
W 0 33
W 0 44
W 0 255
P 22334455
W 0 1a1
W 0 600
E 0 1 0
P 22334455
R 4 55
E 0 1 1

//--- all.f
hw/i2cPkg.sv
hw/syncFifo.sv
hw/apbRegs.sv
hw/i2cBitEngine.sv
hw/apbI2c.sv
test/i2cSlaveModel.sv
test/apbI2cTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = apbI2cTb
FILELIST = all.f
OBJDIR = obj_dir
BIN = $(OBJDIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))
PASS = All tests passed!

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJDIR)
